// File: design/decode_pkg.sv
package decode_pkg;

    localparam int FETCH_WIDTH       = 2;
    localparam int MAX_UOPS_PER_INSN = 2;
    localparam int GROUP_UOPS        = FETCH_WIDTH * MAX_UOPS_PER_INSN;
    localparam int QUEUE_DEPTH       = 8;

    // opcode match values, compared against the top bits of the word
    localparam logic [9:0]  OPC_ADDI = 10'b1001000100;
    localparam logic [9:0]  OPC_SUBI = 10'b1101000100;
    localparam logic [10:0] OPC_ADDS = 11'b10101011000;
    localparam logic [10:0] OPC_SUBS = 11'b11101011000;
    localparam logic [10:0] OPC_ORR  = 11'b10101010000;
    localparam logic [10:0] OPC_EOR  = 11'b11001010000;
    localparam logic [10:0] OPC_ANDS = 11'b11101010000;
    localparam logic [10:0] OPC_LDUR = 11'b11111000010;
    localparam logic [10:0] OPC_STUR = 11'b11111000000;
    localparam logic [8:0]  OPC_MOVZ = 9'b110100101;
    localparam logic [8:0]  OPC_MOVK = 9'b111100101;
    localparam logic [10:0] OPC_HLT  = 11'b11010100010;

    typedef logic [31:0] insn_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [1:0]  move_hw_t;   // 16-bit lane select for wide moves

    typedef logic [$clog2(MAX_UOPS_PER_INSN+1)-1:0] slot_count_t;
    typedef logic [$clog2(GROUP_UOPS+1)-1:0]        uop_count_t;
    typedef logic [$clog2(QUEUE_DEPTH)-1:0]         queue_ptr_t;
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0]       queue_occ_t;

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_ORR,
        UOP_EOR,
        UOP_LOAD,
        UOP_STORE,
        UOP_MOVZ,
        UOP_MOVK,
        UOP_HLT
    } uop_code_t;

    typedef struct packed {
        uop_code_t code;
        reg_idx_t  dst;
        reg_idx_t  src1;
        reg_idx_t  src2;
        imm_t      imm;
        move_hw_t  hw;
        logic      src2_sel;   // 1 selects src2 register, 0 selects imm
        logic      mem_read;
        logic      mem_write;
        logic      w_enable;
        logic      set_flags;
        logic      tx_begin;   // first uop of an instruction
        logic      tx_end;     // last uop of an instruction
    } uop_t;

    localparam int UOP_BITS = $bits(uop_t);

    typedef uop_t [MAX_UOPS_PER_INSN-1:0] slot_uops_t;
    typedef uop_t [GROUP_UOPS-1:0]        uop_group_t;

    // slot 0 holds the older instruction
    typedef struct packed {
        insn_t [FETCH_WIDTH-1:0] insn;
        logic [FETCH_WIDTH-1:0]  slot_valid;
    } fetch_bundle_t;

endpackage

// File: design/slot_decoder.sv
module slot_decoder (
    input  decode_pkg::insn_t       insn,
    input  logic                    slot_valid,
    output decode_pkg::slot_uops_t  uops,
    output decode_pkg::slot_count_t uop_count
);

    logic [9:0]  opc10;
    logic [10:0] opc11;
    logic [8:0]  opc9;
    logic [8:0]  mem_offset;

    decode_pkg::reg_idx_t rd;
    decode_pkg::reg_idx_t rn;
    decode_pkg::reg_idx_t rm;

    logic is_imm_alu;
    logic is_reg_alu;
    logic is_mem;
    logic is_load;
    logic is_move;
    logic is_hlt;

    decode_pkg::uop_t add_uop;   // address add ahead of an offset access
    decode_pkg::uop_t mem_uop;

    assign opc10      = insn[31:22];
    assign opc11      = insn[31:21];
    assign opc9       = insn[31:23];
    assign mem_offset = insn[20:12];
    assign rd         = insn[4:0];
    assign rn         = insn[9:5];
    assign rm         = insn[20:16];

    assign is_imm_alu = (opc10 == decode_pkg::OPC_ADDI) || (opc10 == decode_pkg::OPC_SUBI);
    assign is_reg_alu = opc11 inside {decode_pkg::OPC_ADDS, decode_pkg::OPC_SUBS,
                                      decode_pkg::OPC_ORR, decode_pkg::OPC_EOR,
                                      decode_pkg::OPC_ANDS};
    assign is_load    = opc11 == decode_pkg::OPC_LDUR;
    assign is_mem     = is_load || (opc11 == decode_pkg::OPC_STUR);
    assign is_move    = (opc9 == decode_pkg::OPC_MOVZ) || (opc9 == decode_pkg::OPC_MOVK);
    assign is_hlt     = opc11 == decode_pkg::OPC_HLT;

    function automatic decode_pkg::uop_code_t reg_alu_code(input logic [10:0] opc);
        case (opc)
            decode_pkg::OPC_SUBS: return decode_pkg::UOP_SUB;
            decode_pkg::OPC_ORR:  return decode_pkg::UOP_ORR;
            decode_pkg::OPC_EOR:  return decode_pkg::UOP_EOR;
            decode_pkg::OPC_ANDS: return decode_pkg::UOP_AND;
            default:              return decode_pkg::UOP_ADD;
        endcase
    endfunction

    always_comb begin
        add_uop          = '0;
        add_uop.code     = decode_pkg::UOP_ADD;
        add_uop.dst      = rd;
        add_uop.src1     = rn;
        add_uop.imm      = decode_pkg::imm_t'(mem_offset);
        add_uop.w_enable = 1'b1;
        add_uop.tx_begin = 1'b1;

        mem_uop           = '0;
        mem_uop.code      = is_load ? decode_pkg::UOP_LOAD : decode_pkg::UOP_STORE;
        mem_uop.src1      = (mem_offset == '0) ? rn : rd;   // base is the add result
        mem_uop.dst       = is_load ? rd : '0;
        mem_uop.src2      = is_load ? '0 : rd;              // store data
        mem_uop.mem_read  = is_load;
        mem_uop.mem_write = !is_load;
        mem_uop.w_enable  = is_load;
        mem_uop.tx_end    = 1'b1;
    end

    always_comb begin
        uops      = '0;
        uop_count = 2'd0;
        if (slot_valid) begin
            if (is_imm_alu) begin
                uops[0].code     = (opc10 == decode_pkg::OPC_SUBI) ? decode_pkg::UOP_SUB
                                                                   : decode_pkg::UOP_ADD;
                uops[0].dst      = rd;
                uops[0].src1     = rn;
                uops[0].imm      = decode_pkg::imm_t'(insn[21:10]);
                uops[0].w_enable = 1'b1;
                uops[0].tx_begin = 1'b1;
                uops[0].tx_end   = 1'b1;
                uop_count        = 2'd1;
            end else if (is_reg_alu) begin
                uops[0].code      = reg_alu_code(opc11);
                uops[0].dst       = rd;
                uops[0].src1      = rn;
                uops[0].src2      = rm;
                uops[0].src2_sel  = 1'b1;
                uops[0].set_flags = 1'b1;
                uops[0].w_enable  = 1'b1;
                uops[0].tx_begin  = 1'b1;
                uops[0].tx_end    = 1'b1;
                uop_count         = 2'd1;
            end else if (is_move) begin
                uops[0].code     = (opc9 == decode_pkg::OPC_MOVK) ? decode_pkg::UOP_MOVK
                                                                  : decode_pkg::UOP_MOVZ;
                uops[0].dst      = rd;
                uops[0].imm      = insn[20:5];
                uops[0].hw       = insn[22:21];
                uops[0].w_enable = 1'b1;
                uops[0].tx_begin = 1'b1;
                uops[0].tx_end   = 1'b1;
                uop_count        = 2'd1;
            end else if (is_hlt) begin
                uops[0].code     = decode_pkg::UOP_HLT;
                uops[0].tx_begin = 1'b1;
                uops[0].tx_end   = 1'b1;
                uop_count        = 2'd1;
            end else if (is_mem) begin
                if (mem_offset == '0) begin
                    uops[0]          = mem_uop;
                    uops[0].tx_begin = 1'b1;
                    uop_count        = 2'd1;
                end else begin
                    uops[0]   = add_uop;   // cracked access
                    uops[1]   = mem_uop;
                    uop_count = 2'd2;
                end
            end
        end
    end

endmodule

// File: design/bundle_cracker.sv
module bundle_cracker (
    input  decode_pkg::fetch_bundle_t bundle,
    output decode_pkg::uop_group_t    group,
    output decode_pkg::uop_count_t    group_count
);

    decode_pkg::slot_uops_t  slot_uops  [decode_pkg::FETCH_WIDTH];
    decode_pkg::slot_count_t slot_count [decode_pkg::FETCH_WIDTH];

    genvar s;
    generate
        for (s = 0; s < decode_pkg::FETCH_WIDTH; s++) begin : g_slot
            slot_decoder i_slot_decoder (
                .insn       (bundle.insn[s]),
                .slot_valid (bundle.slot_valid[s]),
                .uops       (slot_uops[s]),
                .uop_count  (slot_count[s])
            );
        end
    endgenerate

    // pack each slot's uops right behind the older slot's, keeping program order
    always_comb begin
        int base;
        base  = 0;
        group = '0;
        for (int i = 0; i < decode_pkg::FETCH_WIDTH; i++) begin
            for (int j = 0; j < decode_pkg::MAX_UOPS_PER_INSN; j++) begin
                if (j < int'(slot_count[i])) begin
                    group[base + j] = slot_uops[i][j];
                end
            end
            base = base + int'(slot_count[i]);
        end
        group_count = decode_pkg::uop_count_t'(base);
    end

endmodule

// File: design/uop_queue.sv
module uop_queue (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   push,
    input  decode_pkg::uop_group_t group,
    input  decode_pkg::uop_count_t group_count,
    input  logic                   pop,
    output decode_pkg::uop_t       head,
    output logic                   head_valid,
    output logic                   space_ok
);

    decode_pkg::uop_t entries [decode_pkg::QUEUE_DEPTH];

    decode_pkg::queue_ptr_t rd_ptr;
    decode_pkg::queue_ptr_t wr_ptr;
    decode_pkg::queue_occ_t occ;
    decode_pkg::queue_occ_t occ_next;
    decode_pkg::queue_occ_t push_n;
    decode_pkg::queue_occ_t pop_n;

    assign push_n = push ? decode_pkg::queue_occ_t'(group_count) : '0;
    assign pop_n  = pop ? decode_pkg::queue_occ_t'(1) : '0;

    always_comb begin
        if (flush) begin
            occ_next = '0;
        end else begin
            occ_next = occ + push_n - pop_n;
        end
    end

    // nothing leaves the queue in a flush cycle
    assign head       = entries[rd_ptr];
    assign head_valid = (occ != '0) && !flush;

    always_ff @(posedge clk_in) begin
        if (push && !flush) begin
            for (int i = 0; i < decode_pkg::GROUP_UOPS; i++) begin
                if (i < int'(group_count)) begin
                    entries[wr_ptr + decode_pkg::queue_ptr_t'(i)] <= group[i];
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            occ      <= '0;
            space_ok <= 1'b0;
        end else begin
            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + decode_pkg::queue_ptr_t'(push_n);
                rd_ptr <= rd_ptr + decode_pkg::queue_ptr_t'(pop_n);
            end
            occ <= occ_next;
            // room for a full group next cycle
            space_ok <= occ_next <= decode_pkg::queue_occ_t'(decode_pkg::QUEUE_DEPTH
                                                             - decode_pkg::GROUP_UOPS);
        end
    end

endmodule

// File: design/uop_issue_wb.sv
module uop_issue_wb (
    input  logic             clk_in,
    input  logic             reset,
    input  decode_pkg::uop_t head,
    input  logic             head_valid,
    output logic             pop,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output decode_pkg::uop_t wb_dat,
    input  logic             wb_ack
);

    typedef enum logic {
        ISSUE_IDLE,
        ISSUE_BUSY
    } issue_state_t;

    issue_state_t state;
    logic         xfer_done;
    logic         load;

    assign xfer_done = (state == ISSUE_BUSY) && wb_ack;
    assign load      = head_valid && ((state == ISSUE_IDLE) || xfer_done);
    assign pop       = load;   // head is taken at the coming edge

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ISSUE_IDLE;
        end else begin
            case (state)
                ISSUE_IDLE: begin
                    if (head_valid) begin
                        state <= ISSUE_BUSY;
                    end
                end
                ISSUE_BUSY: begin
                    if (wb_ack && !head_valid) begin
                        state <= ISSUE_IDLE;
                    end
                end
                default: state <= ISSUE_IDLE;
            endcase
        end
    end

    // held until the slave acks
    always_ff @(posedge clk_in) begin
        if (load) begin
            wb_dat <= head;
        end
    end

    assign wb_cyc = state == ISSUE_BUSY;
    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc;   // issue is write only

endmodule

// File: design/decode_stage.sv
module decode_stage (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      flush,
    input  decode_pkg::fetch_bundle_t bundle,
    input  logic                      bundle_valid,
    output logic                      bundle_ready,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output decode_pkg::uop_t          wb_dat,
    input  logic                      wb_ack
);

    decode_pkg::uop_group_t group;
    decode_pkg::uop_count_t group_count;
    decode_pkg::uop_t       head;
    logic                   head_valid;
    logic                   space_ok;
    logic                   push;
    logic                   pop;

    assign bundle_ready = space_ok && !flush;
    assign push         = bundle_valid && bundle_ready;

    bundle_cracker i_bundle_cracker (
        .bundle      (bundle),
        .group       (group),
        .group_count (group_count)
    );

    uop_queue i_uop_queue (
        .clk_in      (clk_in),
        .reset       (reset),
        .flush       (flush),
        .push        (push),
        .group       (group),
        .group_count (group_count),
        .pop         (pop),
        .head        (head),
        .head_valid  (head_valid),
        .space_ok    (space_ok)
    );

    uop_issue_wb i_uop_issue_wb (
        .clk_in     (clk_in),
        .reset      (reset),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack)
    );

endmodule

// File: verif/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected uops in issue order, oldest at index 0
decode_pkg::uop_t expected[$];

// appends the uops that one slot should produce
function automatic void push_expected(input decode_pkg::insn_t w, input logic valid);
    decode_pkg::uop_t u;
    decode_pkg::uop_t mem;
    logic [8:0]       off;
    if (!valid) begin
        return;
    end
    off        = w[20:12];
    u          = '0;
    u.dst      = w[4:0];
    u.src1     = w[9:5];
    u.w_enable = 1'b1;
    u.tx_begin = 1'b1;
    u.tx_end   = 1'b1;
    if (w[31:22] == decode_pkg::OPC_ADDI || w[31:22] == decode_pkg::OPC_SUBI) begin
        u.code = (w[31:22] == decode_pkg::OPC_SUBI) ? decode_pkg::UOP_SUB : decode_pkg::UOP_ADD;
        u.imm  = {4'b0000, w[21:10]};   // zero extended
        expected.push_back(u);
    end else if (w[31:21] inside {decode_pkg::OPC_ADDS, decode_pkg::OPC_SUBS,
                                  decode_pkg::OPC_ORR, decode_pkg::OPC_EOR,
                                  decode_pkg::OPC_ANDS}) begin
        case (w[31:21])
            decode_pkg::OPC_ADDS: u.code = decode_pkg::UOP_ADD;
            decode_pkg::OPC_SUBS: u.code = decode_pkg::UOP_SUB;
            decode_pkg::OPC_ORR:  u.code = decode_pkg::UOP_ORR;
            decode_pkg::OPC_EOR:  u.code = decode_pkg::UOP_EOR;
            default:              u.code = decode_pkg::UOP_AND;
        endcase
        u.src2      = w[20:16];
        u.src2_sel  = 1'b1;
        u.set_flags = 1'b1;
        expected.push_back(u);
    end else if (w[31:23] == decode_pkg::OPC_MOVZ || w[31:23] == decode_pkg::OPC_MOVK) begin
        u.code = (w[31:23] == decode_pkg::OPC_MOVK) ? decode_pkg::UOP_MOVK : decode_pkg::UOP_MOVZ;
        u.src1 = '0;
        u.imm  = w[20:5];
        u.hw   = w[22:21];
        expected.push_back(u);
    end else if (w[31:21] == decode_pkg::OPC_HLT) begin
        u          = '0;
        u.code     = decode_pkg::UOP_HLT;
        u.tx_begin = 1'b1;
        u.tx_end   = 1'b1;
        expected.push_back(u);
    end else if (w[31:21] == decode_pkg::OPC_LDUR || w[31:21] == decode_pkg::OPC_STUR) begin
        mem        = '0;
        mem.src1   = w[9:5];
        mem.tx_end = 1'b1;
        if (w[31:21] == decode_pkg::OPC_LDUR) begin
            mem.code     = decode_pkg::UOP_LOAD;
            mem.dst      = w[4:0];
            mem.mem_read = 1'b1;
            mem.w_enable = 1'b1;
        end else begin
            mem.code      = decode_pkg::UOP_STORE;
            mem.src2      = w[4:0];
            mem.mem_write = 1'b1;
        end
        if (off != '0) begin
            u.imm    = {7'b0000000, off};   // address add into the data register
            u.tx_end = 1'b0;
            expected.push_back(u);
            mem.src1 = w[4:0];
        end else begin
            mem.tx_begin = 1'b1;
        end
        expected.push_back(mem);
    end
endfunction

`endif

// File: verif/decode_tb.sv
module decode_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 10;
    localparam int TEST_BUNDLES = 32;

    logic                      clk_in;
    logic                      reset;
    logic                      flush;
    decode_pkg::fetch_bundle_t bundle;
    logic                      bundle_valid;
    logic                      bundle_ready;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    decode_pkg::uop_t          wb_dat;
    logic                      wb_ack;

    logic             stall;
    logic             stb_at_flush;
    logic             held_valid;   // a write was pending at the last edge
    decode_pkg::uop_t held_dat;
    int               ack_delay;
    int               stb_cycles;

    `include "decode_model.svh"

    decode_stage i_decode_stage (
        .clk_in       (clk_in),
        .reset        (reset),
        .flush        (flush),
        .bundle       (bundle),
        .bundle_valid (bundle_valid),
        .bundle_ready (bundle_ready),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    task automatic fail_run(input string what);
        $display("%s at %0t", what, $time);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        fail_run("value mismatch");
    endtask

    // instruction builders, fields as the encodings lay them out
    function automatic decode_pkg::insn_t enc_r(input logic [10:0] opc, input int rm, rn, rd);
        return {opc, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
    endfunction

    function automatic decode_pkg::insn_t enc_i(input logic [9:0] opc, input int imm, rn, rd);
        return {opc, 12'(imm), 5'(rn), 5'(rd)};
    endfunction

    function automatic decode_pkg::insn_t enc_d(input logic [10:0] opc, input int off, rn, rt);
        return {opc, 9'(off), 2'b00, 5'(rn), 5'(rt)};
    endfunction

    function automatic decode_pkg::insn_t enc_m(input logic [8:0] opc, input int hw, imm, rd);
        return {opc, 2'(hw), 16'(imm), 5'(rd)};
    endfunction

    function automatic decode_pkg::fetch_bundle_t make_bundle(input decode_pkg::insn_t i0,
                                                              input logic v0,
                                                              input decode_pkg::insn_t i1,
                                                              input logic v1);
        decode_pkg::fetch_bundle_t b;
        b.insn[0]       = i0;
        b.insn[1]       = i1;
        b.slot_valid[0] = v0;
        b.slot_valid[1] = v1;
        return b;
    endfunction

    // wishbone slave, acks after 0 to 3 extra cycles unless stalled
    always @(posedge clk_in) begin
        if (reset || stall || !wb_stb || wb_ack) begin
            wb_ack    <= 1'b0;
            ack_delay <= $urandom_range(3, 0);
        end else if (ack_delay == 0) begin
            wb_ack <= 1'b1;
        end else begin
            ack_delay <= ack_delay - 1;
        end
    end

    // scoreboard
    always @(posedge clk_in) begin
        if (reset) begin
            assert (!wb_stb) else fail_value("wb_stb", wb_stb, 1'b0);
            held_valid = 1'b0;
        end else begin
            assert (wb_cyc == wb_stb) else fail_value("wb_cyc", wb_cyc, wb_stb);
            if (held_valid) begin
                // an unacked write keeps its request and its data
                assert (wb_stb) else fail_value("wb_stb", wb_stb, 1'b1);
                assert (wb_dat == held_dat)
                    else fail_value("wb_dat", 64'(wb_dat), 64'(held_dat));
            end
            if (wb_stb) begin
                stb_cycles++;
                assert (wb_we) else fail_value("wb_we", wb_we, 1'b1);
            end
            if (wb_stb && wb_ack) begin
                assert (expected.size() != 0) else fail_run("uop issued with none expected");
                assert (wb_dat == expected[0])
                    else fail_value("wb_dat", 64'(wb_dat), 64'(expected[0]));
                void'(expected.pop_front());
            end
            if (bundle_valid && bundle_ready) begin
                push_expected(bundle.insn[0], bundle.slot_valid[0]);
                push_expected(bundle.insn[1], bundle.slot_valid[1]);
            end
            if (flush) begin
                assert (!bundle_ready) else fail_value("bundle_ready", bundle_ready, 1'b0);
                stb_at_flush = wb_stb && !wb_ack;
                while (expected.size() > (stb_at_flush ? 1 : 0)) begin
                    void'(expected.pop_back());
                end
            end
            // queue entries plus the issue register
            assert (expected.size() <= decode_pkg::QUEUE_DEPTH + 1)
                else fail_run("more uops pending than the queue can hold");
            held_valid = wb_stb && !wb_ack;
            held_dat   = wb_dat;
        end
    end

    initial begin
        #(CLK_PERIOD * (TEST_BUNDLES * 200 + 2000));
        fail_run("timeout waiting for the DUT");
    end

    task automatic offer(input decode_pkg::fetch_bundle_t b);
        bundle       <= b;
        bundle_valid <= 1'b1;
        do @(posedge clk_in); while (!bundle_ready);
        bundle_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk_in);
        while (expected.size() != 0 || wb_stb) @(posedge clk_in);
    endtask

    task automatic test_reset_alu();
        repeat (3) begin
            @(posedge clk_in);
            assert (!wb_stb) else fail_value("wb_stb", wb_stb, 1'b0);
        end
        assert (bundle_ready) else fail_value("bundle_ready", bundle_ready, 1'b1);
        offer(make_bundle(enc_i(decode_pkg::OPC_ADDI, 12'habc, 3, 4), 1'b1,
                          enc_i(decode_pkg::OPC_SUBI, 7, 31, 0), 1'b1));
        offer(make_bundle(enc_r(decode_pkg::OPC_ADDS, 1, 2, 3), 1'b1,
                          enc_r(decode_pkg::OPC_SUBS, 4, 5, 6), 1'b1));
        offer(make_bundle(enc_r(decode_pkg::OPC_ORR, 7, 8, 9), 1'b1,
                          enc_r(decode_pkg::OPC_EOR, 10, 11, 12), 1'b1));
        offer(make_bundle(enc_r(decode_pkg::OPC_ANDS, 13, 14, 15), 1'b1, '0, 1'b0));
        drain();
    endtask

    task automatic test_memory();
        offer(make_bundle(enc_d(decode_pkg::OPC_LDUR, 0, 1, 2), 1'b1,
                          enc_d(decode_pkg::OPC_STUR, 0, 3, 4), 1'b1));
        offer(make_bundle(enc_d(decode_pkg::OPC_LDUR, 9'h1f0, 5, 6), 1'b1,
                          enc_d(decode_pkg::OPC_STUR, 8, 7, 8), 1'b1));   // four uops
        offer(make_bundle(enc_i(decode_pkg::OPC_ADDI, 1, 1, 1), 1'b1,
                          enc_d(decode_pkg::OPC_STUR, 1, 9, 10), 1'b1));
        drain();
    endtask

    task automatic test_moves_dropped();
        int stb_before;
        offer(make_bundle(enc_m(decode_pkg::OPC_MOVZ, 2, 16'hbeef, 3), 1'b1,
                          enc_m(decode_pkg::OPC_MOVK, 3, 16'h1234, 3), 1'b1));
        offer(make_bundle({decode_pkg::OPC_HLT, 21'd0}, 1'b1, 32'hd503201f, 1'b1));
        drain();
        stb_before = stb_cycles;
        offer(make_bundle(32'hd503201f, 1'b1, 32'h0000_0000, 1'b1));
        offer(make_bundle(enc_r(decode_pkg::OPC_ADDS, 1, 2, 3), 1'b0,
                          enc_d(decode_pkg::OPC_LDUR, 4, 5, 6), 1'b0));   // both slots invalid
        repeat (6) @(posedge clk_in);
        assert (stb_cycles == stb_before) else fail_value("stb_cycles", stb_cycles, stb_before);
    endtask

    task automatic test_backpressure();
        bit saw_full;
        saw_full = 0;
        stall        <= 1'b1;
        bundle_valid <= 1'b1;
        for (int i = 0; i < 20 && !saw_full; i++) begin
            bundle <= make_bundle(enc_d(decode_pkg::OPC_LDUR, $urandom_range(255, 1), i, 2), 1'b1,
                                  enc_r(decode_pkg::OPC_EOR, $urandom_range(31, 0), i, 5), 1'b1);
            @(posedge clk_in);
            saw_full = !bundle_ready;
        end
        bundle_valid <= 1'b0;
        assert (saw_full) else fail_run("bundle_ready never fell with the slave stalled");
        repeat (5) @(posedge clk_in);
        stall <= 1'b0;
        drain();
    endtask

    task automatic test_flush();
        stall <= 1'b1;
        offer(make_bundle(enc_r(decode_pkg::OPC_ADDS, 1, 1, 1), 1'b1,
                          enc_d(decode_pkg::OPC_STUR, 3, 2, 2), 1'b1));
        offer(make_bundle(enc_m(decode_pkg::OPC_MOVZ, 0, 5, 5), 1'b1, '0, 1'b0));
        repeat (3) @(posedge clk_in);
        flush        <= 1'b1;
        bundle       <= make_bundle(enc_i(decode_pkg::OPC_ADDI, 9, 9, 9), 1'b1, '0, 1'b0);
        bundle_valid <= 1'b1;   // must not be taken
        @(posedge clk_in);
        flush        <= 1'b0;
        bundle_valid <= 1'b0;
        @(posedge clk_in);
        // the write on the bus stays, nothing new starts from the emptied queue
        assert (wb_stb == stb_at_flush) else fail_value("wb_stb", wb_stb, stb_at_flush);
        offer(make_bundle(enc_r(decode_pkg::OPC_ORR, 3, 4, 5), 1'b1,
                          enc_m(decode_pkg::OPC_MOVK, 1, 16'h00ff, 6), 1'b1));
        stall <= 1'b0;
        drain();
    endtask

    initial begin
        void'($urandom(32'he12cd298));
        reset        = 1'b1;
        flush        = 1'b0;
        bundle       = '0;
        bundle_valid = 1'b0;
        wb_ack       = 1'b0;
        stall        = 1'b0;
        stb_at_flush = 1'b0;
        ack_delay    = 0;
        stb_cycles   = 0;
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;
        test_reset_alu();
        test_memory();
        test_moves_dropped();
        test_backpressure();
        test_flush();
        repeat (4) @(posedge clk_in);
        if (expected.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected uops never issued", expected.size()));
        end
    end

endmodule

// File: sim.f
+incdir+verif
design/decode_pkg.sv
design/slot_decoder.sv
design/bundle_cracker.sv
design/uop_queue.sv
design/uop_issue_wb.sv
design/decode_stage.sv
verif/decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= sim.f
TB_TOP    ?= decode_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(wildcard design/*.sv verif/*.sv verif/*.svh)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
